// File: common/shell_params.svh
`ifndef SHELL_PARAMS_SVH
`define SHELL_PARAMS_SVH

`define SHELL_STATUS_W 32
`define SHELL_DAC_W    12

// command bytes that open an SPI frame on the user channel
`define SPI_CMD_BUTTONS 8'h01
`define SPI_CMD_JOY0    8'h02
`define SPI_CMD_JOY1    8'h03
`define SPI_CMD_STATUS  8'h1E
`define SPI_CMD_KBD     8'h05

// arrow keys only count after the E0 prefix
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_LEFT   8'h6B
`define KEY_RIGHT  8'h74
`define KEY_FIRE   8'h29
`define KEY_START1 8'h16
`define KEY_START2 8'h1E
`define KEY_COIN   8'h2E
`define KEY_EXT    8'hE0
`define KEY_BREAK  8'hF0

`endif

// File: common/shell_pkg.sv
`include "shell_params.svh"

package shell_pkg;

typedef logic [`SHELL_STATUS_W-1:0] status_t;     // bit 0 reset, bit 2 rotate, bit 6 menu reset
typedef logic                 [7:0] joy_t;        // 0 right, 1 left, 2 down, 3 up, 4 fire
typedef logic                 [3:0] board_btn_t;  // buttons in [1:0], switches in [3:2]
typedef logic                 [7:0] scan_code_t;
typedef logic    [`SHELL_DAC_W-1:0] audio_sample_t;  // upper bits of the core's audio

typedef struct packed {
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic start1;
	logic start2;
	logic coin;
} key_state_t;

typedef struct packed {
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic start1;
	logic start2;
	logic coin;
} controls_t;

typedef struct packed {
	status_t    status;
	board_btn_t btn;
	joy_t       joy0;
	joy_t       joy1;
} host_regs_t;

endpackage

// File: spi_user_io/spi_user_io.sv
`timescale 1ns/100ps
`include "shell_params.svh"

module spi_user_io
	import shell_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       spi_sck,
	input  logic       spi_ss,     // active low
	input  logic       spi_di,
	output host_regs_t regs,
	output scan_code_t kbd_byte,
	output logic       kbd_valid
);

typedef enum logic [1:0] {
	ST_IDLE,
	ST_COMMAND,
	ST_PAYLOAD
} spi_state_t;

spi_state_t  state;
logic  [2:0] sck_pipe;
logic  [2:0] ss_pipe;
logic  [1:0] di_pipe;
logic  [6:0] shift_q;
logic  [2:0] bit_cnt;
logic  [2:0] byte_idx;
logic  [7:0] cmd;
logic [23:0] status_lo;
logic  [7:0] rx_byte;
logic        sck_rise;
logic        ss_fall;
logic        ss_active;
logic        byte_done;
logic        payload_done;
logic        cmd_known;

// ~~~~~~~~~~~~~~~~~~~~ line synchronizers

always_ff @(posedge clk_sys) begin
	if (reset) begin
		sck_pipe <= '0;
		ss_pipe  <= '1;
	end else begin
		sck_pipe <= {sck_pipe[1:0], spi_sck};
		ss_pipe  <= {ss_pipe[1:0], spi_ss};
	end
end

always_ff @(posedge clk_sys) begin
	di_pipe <= {di_pipe[0], spi_di};
end

assign sck_rise  = sck_pipe[1] & ~sck_pipe[2];
assign ss_fall   = ss_pipe[2] & ~ss_pipe[1];
assign ss_active = ~ss_pipe[1];

// ~~~~~~~~~~~~~~~~~~~~ byte assembly

always_ff @(posedge clk_sys) begin
	if (reset || !ss_active) bit_cnt <= '0;  // a byte cut short by ss is dropped
	else if (sck_rise) bit_cnt <= bit_cnt + 3'd1;
end

always_ff @(posedge clk_sys) begin
	if (sck_rise) shift_q <= rx_byte[6:0];  // msb first
end

assign rx_byte      = {shift_q, di_pipe[1]};
assign byte_done    = ss_active & sck_rise & (bit_cnt == 3'd7);
assign payload_done = byte_done & (state == ST_PAYLOAD);
assign cmd_known    = rx_byte inside {`SPI_CMD_BUTTONS, `SPI_CMD_JOY0, `SPI_CMD_JOY1,
	`SPI_CMD_STATUS, `SPI_CMD_KBD};

// ~~~~~~~~~~~~~~~~~~~~ frame decode

always_ff @(posedge clk_sys) begin
	kbd_valid <= 1'b0;
	if (reset) begin
		state    <= ST_IDLE;
		cmd      <= '0;
		byte_idx <= '0;
		regs     <= '0;
	end else if (!ss_active) begin
		state <= ST_IDLE;
	end else begin
		case (state)
			ST_IDLE: if (ss_fall) state <= ST_COMMAND;  // rest of a finished frame is ignored
			ST_COMMAND: if (byte_done) begin
				cmd      <= rx_byte;
				byte_idx <= '0;
				state    <= cmd_known ? ST_PAYLOAD : ST_IDLE;
			end
			ST_PAYLOAD: if (byte_done) begin
				state <= ST_IDLE;
				case (cmd)
					`SPI_CMD_BUTTONS: regs.btn  <= rx_byte[3:0];
					`SPI_CMD_JOY0:    regs.joy0 <= rx_byte;
					`SPI_CMD_JOY1:    regs.joy1 <= rx_byte;
					`SPI_CMD_KBD:     kbd_valid <= 1'b1;
					`SPI_CMD_STATUS: begin
						if (byte_idx == 3'd3) begin
							regs.status <= {rx_byte, status_lo};  // whole word at once
						end else begin
							byte_idx <= byte_idx + 3'd1;
							state    <= ST_PAYLOAD;
						end
					end
					default: ;
				endcase
			end
			default: state <= ST_IDLE;
		endcase
	end
end

always_ff @(posedge clk_sys) begin
	if (payload_done && cmd == `SPI_CMD_KBD) kbd_byte <= rx_byte;
	if (payload_done && cmd == `SPI_CMD_STATUS) begin
		case (byte_idx)
			3'd0:    status_lo[7:0]   <= rx_byte;
			3'd1:    status_lo[15:8]  <= rx_byte;
			3'd2:    status_lo[23:16] <= rx_byte;
			default: ;
		endcase
	end
end

a_byte_idx: assert property (@(posedge clk_sys) disable iff (reset) byte_idx <= 3'd3);
a_kbd_pulse: assert property (@(posedge clk_sys) disable iff (reset) kbd_valid |=> !kbd_valid);

endmodule

// File: rtl/ps2_key_decoder.sv
`timescale 1ns/100ps
`include "shell_params.svh"

module ps2_key_decoder
	import shell_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  scan_code_t kbd_byte,
	input  logic       kbd_valid,
	output key_state_t keys
);

typedef enum logic [1:0] {
	KS_IDLE,
	KS_EXT,
	KS_BREAK,
	KS_EXT_BREAK
} kbd_state_t;

kbd_state_t state;
logic       is_ext;
logic       is_break;
logic       make;

assign is_ext   = (state == KS_EXT) || (state == KS_EXT_BREAK);
assign is_break = (state == KS_BREAK) || (state == KS_EXT_BREAK);
assign make     = ~is_break;

always_ff @(posedge clk_sys) begin
	if (reset) begin
		state <= KS_IDLE;
		keys  <= '0;
	end else if (kbd_valid) begin
		if (kbd_byte == `KEY_EXT) begin
			state <= is_break ? KS_EXT_BREAK : KS_EXT;
		end else if (kbd_byte == `KEY_BREAK) begin
			state <= is_ext ? KS_EXT_BREAK : KS_BREAK;
		end else begin
			state <= KS_IDLE;  // any final code ends the sequence
			if (is_ext) begin
				case (kbd_byte)
					`KEY_UP:    keys.up    <= make;
					`KEY_DOWN:  keys.down  <= make;
					`KEY_LEFT:  keys.left  <= make;
					`KEY_RIGHT: keys.right <= make;
					default: ;
				endcase
			end else begin
				case (kbd_byte)
					`KEY_FIRE:   keys.fire   <= make;
					`KEY_START1: keys.start1 <= make;
					`KEY_START2: keys.start2 <= make;
					`KEY_COIN:   keys.coin   <= make;
					default: ;
				endcase
			end
		end
	end
end

// only a prefix byte may take the machine out of idle
a_idle_exit: assert property (@(posedge clk_sys) disable iff (reset)
	state == KS_IDLE && !(kbd_valid && kbd_byte inside {`KEY_EXT, `KEY_BREAK})
	|=> state == KS_IDLE);

endmodule

// File: rtl/control_mapper.sv
`timescale 1ns/100ps

module control_mapper
	import shell_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  host_regs_t regs,
	input  key_state_t keys,
	output controls_t  controls,
	output logic       core_reset
);

logic src_up;
logic src_down;
logic src_left;
logic src_right;
logic rotate;

// joystick bits are 3 up, 2 down, 1 left, 0 right
assign src_up    = keys.up    | regs.joy0[3] | regs.joy1[3];
assign src_down  = keys.down  | regs.joy0[2] | regs.joy1[2];
assign src_left  = keys.left  | regs.joy0[1] | regs.joy1[1];
assign src_right = keys.right | regs.joy0[0] | regs.joy1[0];
assign rotate    = regs.status[2];

always_ff @(posedge clk_sys) begin
	core_reset <= reset | regs.status[0] | regs.status[6] | regs.btn[1];
	if (reset) begin
		controls <= '0;
	end else begin
		controls.up     <= rotate ? src_left  : src_up;  // cabinet turned a quarter
		controls.down   <= rotate ? src_right : src_down;
		controls.left   <= rotate ? src_down  : src_left;
		controls.right  <= rotate ? src_up    : src_right;
		controls.fire   <= keys.fire | regs.joy0[4] | regs.joy1[4];
		controls.start1 <= keys.start1;
		controls.start2 <= keys.start2;
		controls.coin   <= keys.coin;
	end
end

endmodule

// File: rtl/sigma_delta_dac.sv
`timescale 1ns/100ps
`include "shell_params.svh"

module sigma_delta_dac
	import shell_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  audio_sample_t sample,
	output logic          dac_out
);

logic [`SHELL_DAC_W:0] acc;

// the carry of the running sum is the pulse density output
always_ff @(posedge clk_sys) begin
	if (reset) begin
		acc     <= '0;
		dac_out <= 1'b0;
	end else begin
		acc     <= {1'b0, acc[`SHELL_DAC_W-1:0]} + {1'b0, sample};
		dac_out <= acc[`SHELL_DAC_W];
	end
end

a_quiet_after_reset: assert property (@(posedge clk_sys) reset |=> !dac_out);

endmodule

// File: rtl/arcade_shell.sv
`timescale 1ns/100ps

module arcade_shell
	import shell_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        spi_sck,
	input  logic        spi_ss,    // active low
	input  logic        spi_di,
	input  logic [15:0] audio,
	output controls_t   controls,
	output logic        core_reset,
	output logic        audio_out
);

host_regs_t regs;
scan_code_t kbd_byte;
logic       kbd_valid;
key_state_t keys;

spi_user_io i_spi_user_io (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.spi_sck   (spi_sck),
	.spi_ss    (spi_ss),
	.spi_di    (spi_di),
	.regs      (regs),
	.kbd_byte  (kbd_byte),
	.kbd_valid (kbd_valid)
);

ps2_key_decoder i_ps2_key_decoder (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.kbd_byte  (kbd_byte),
	.kbd_valid (kbd_valid),
	.keys      (keys)
);

control_mapper i_control_mapper (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.regs       (regs),
	.keys       (keys),
	.controls   (controls),
	.core_reset (core_reset)
);

sigma_delta_dac i_sigma_delta_dac (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sample  (audio[15:4]),  // low nibble is below the dac resolution
	.dac_out (audio_out)
);

endmodule

// File: dv/tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~ spi driver

task automatic hold(input int cycles);
	repeat (cycles) @(posedge clk_sys);
	#1;
endtask

task automatic spi_open(output int half);
	half   = $urandom_range(8, 4);  // half period in clk_sys cycles
	spi_ss = 1'b0;
	hold(half);
endtask

task automatic spi_byte(input logic [7:0] value, input int nbits, input int half);
	for (int i = 7; i > 7 - nbits; i--) begin
		spi_sck = 1'b0;
		spi_di  = value[i];  // msb first
		hold(half);
		spi_sck = 1'b1;
		hold(half);
	end
endtask

task automatic spi_close(input int half);
	spi_sck = 1'b0;
	hold(half);
	spi_ss = 1'b1;
	hold(half);
endtask

task automatic send_reg(input logic [7:0] cmd, input logic [7:0] value);
	int half;
	spi_open(half);
	spi_byte(cmd, 8, half);
	spi_byte(value, 8, half);
	spi_close(half);
endtask

task automatic send_status(input status_t word);
	int half;
	spi_open(half);
	spi_byte(`SPI_CMD_STATUS, 8, half);
	for (int b = 0; b < 4; b++) begin
		spi_byte(word[8*b +: 8], 8, half);  // least significant byte first
	end
	spi_close(half);
endtask

// the frame ends while a byte is still being shifted
task automatic send_cut_kbd(input logic in_command, input int nbits);
	int          half;
	logic [31:0] rnd;
	rnd = $urandom;
	spi_open(half);
	if (!in_command) spi_byte(`SPI_CMD_KBD, 8, half);
	spi_byte(rnd[7:0], nbits, half);
	spi_close(half);
endtask

// ~~~~~~~~~~~~~~~~~~~~ reference model

task automatic model_scan(input scan_code_t code);
	logic pressed;
	pressed = ~model_brk;
	if (code == `KEY_EXT) begin
		model_ext = 1'b1;
	end else if (code == `KEY_BREAK) begin
		model_brk = 1'b1;
	end else begin
		if (model_ext) begin
			case (code)
				`KEY_UP:    model_keys.up    = pressed;
				`KEY_DOWN:  model_keys.down  = pressed;
				`KEY_LEFT:  model_keys.left  = pressed;
				`KEY_RIGHT: model_keys.right = pressed;
				default: ;
			endcase
		end else begin
			case (code)
				`KEY_FIRE:   model_keys.fire   = pressed;
				`KEY_START1: model_keys.start1 = pressed;
				`KEY_START2: model_keys.start2 = pressed;
				`KEY_COIN:   model_keys.coin   = pressed;
				default: ;
			endcase
		end
		model_ext = 1'b0;  // every final code closes the prefix sequence
		model_brk = 1'b0;
	end
endtask

function automatic controls_t expected_controls();
	controls_t c;
	logic      up_src;
	logic      down_src;
	logic      left_src;
	logic      right_src;
	up_src    = model_keys.up    | model_regs.joy0[3] | model_regs.joy1[3];
	down_src  = model_keys.down  | model_regs.joy0[2] | model_regs.joy1[2];
	left_src  = model_keys.left  | model_regs.joy0[1] | model_regs.joy1[1];
	right_src = model_keys.right | model_regs.joy0[0] | model_regs.joy1[0];
	if (model_regs.status[2]) begin
		c.up    = left_src;
		c.down  = right_src;
		c.left  = down_src;
		c.right = up_src;
	end else begin
		c.up    = up_src;
		c.down  = down_src;
		c.left  = left_src;
		c.right = right_src;
	end
	c.fire   = model_keys.fire | model_regs.joy0[4] | model_regs.joy1[4];
	c.start1 = model_keys.start1;
	c.start2 = model_keys.start2;
	c.coin   = model_keys.coin;
	return c;
endfunction

function automatic logic expected_reset();
	return reset | model_regs.status[0] | model_regs.status[6] | model_regs.btn[1];
endfunction

// ~~~~~~~~~~~~~~~~~~~~ checks

task automatic check_controls(input controls_t got, input controls_t exp, input string what);
	if (got !== exp) begin
		ctrl_errors++;
		$display("error at %0t: controls %s got %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_reset(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		reset_errors++;
		$display("error at %0t: %s got %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_dac_count(input audio_sample_t got, input audio_sample_t exp,
	input string what);
	int diff;
	diff = int'(got) - int'(exp);
	if (diff > 1 || diff < -1) begin
		dac_errors++;
		$display("error at %0t: %s got %0d ones expected %0d", $time, what, got, exp);
	end
endtask

task automatic settle_and_check(input string what);
	controls_t exp_c;
	logic      exp_r;
	int        waited;
	exp_c  = expected_controls();
	exp_r  = expected_reset();
	waited = 0;
	while ((controls !== exp_c || core_reset !== exp_r) && waited < SETTLE_LIMIT) begin
		@(posedge clk_sys);
		#1;
		waited++;
	end
	if (controls !== exp_c || core_reset !== exp_r) begin
		wait_timeouts++;
		$display("timeout: outputs did not settle after %s", what);
	end
	check_controls(controls, exp_c, what);
	check_reset(core_reset, exp_r, {"core_reset ", what});
endtask

// ~~~~~~~~~~~~~~~~~~~~ stimulus

task automatic random_host_frame(input logic keep_running);
	logic [31:0] rnd;
	status_t     word;
	rnd  = $urandom;
	word = $urandom;
	if (keep_running) begin
		rnd[9]  = 1'b0;  // buttons bit 1 would hold the core in reset
		word[0] = 1'b0;
		word[6] = 1'b0;
	end
	case (rnd[1:0])
		2'd0: begin
			model_regs.joy0 = rnd[15:8];
			send_reg(`SPI_CMD_JOY0, rnd[15:8]);
		end
		2'd1: begin
			model_regs.joy1 = rnd[15:8];
			send_reg(`SPI_CMD_JOY1, rnd[15:8]);
		end
		2'd2: begin
			model_regs.btn = rnd[11:8];
			send_reg(`SPI_CMD_BUTTONS, rnd[15:8]);
		end
		default: begin
			model_regs.status = word;
			send_status(word);
		end
	endcase
	settle_and_check($sformatf("host frame %0d", rnd[1:0]));
endtask

task automatic random_scan_step();
	logic [31:0] rnd;
	scan_code_t  code;
	rnd = $urandom;
	case (rnd[3:0])
		4'd0, 4'd1, 4'd2: code = `KEY_EXT;
		4'd3, 4'd4:       code = `KEY_BREAK;
		4'd5:             code = `KEY_UP;
		4'd6:             code = `KEY_DOWN;
		4'd7:             code = `KEY_LEFT;
		4'd8:             code = `KEY_RIGHT;
		4'd9:             code = `KEY_FIRE;
		4'd10:            code = `KEY_START1;
		4'd11:            code = `KEY_START2;
		4'd12:            code = `KEY_COIN;
		default:          code = rnd[15:8];  // mostly codes the decoder drops
	endcase
	if (rnd[3:0] >= 4'd14) begin
		send_cut_kbd(rnd[20], $urandom_range(7, 1));
		settle_and_check("cut frame");
	end else begin
		model_scan(code);
		send_reg(`SPI_CMD_KBD, code);
		settle_and_check($sformatf("scan code %h", code));
	end
endtask

task automatic measure_dac();
	logic [31:0]   rnd;
	logic [31:0]   low;
	audio_sample_t sample;
	audio_sample_t ones;
	rnd    = $urandom_range(4094, 0);
	low    = $urandom;
	sample = rnd[11:0];
	audio  = {sample, low[3:0]};
	hold(4);  // flush the previous sample out of the accumulator path
	ones = '0;
	repeat (4096) begin
		@(posedge clk_sys);
		#1;
		if (audio_out) ones = ones + audio_sample_t'(1);
	end
	check_dac_count(ones, sample, "constant audio");
endtask

// File: dv/tb_arcade_shell.sv
`timescale 1ns/100ps
`include "shell_params.svh"

module tb_arcade_shell
	import shell_pkg::*;
();

localparam int SETTLE_LIMIT = 64;  // cycles from end of a frame to stable outputs

logic        clk_sys;
logic        reset;
logic        spi_sck;
logic        spi_ss;
logic        spi_di;
logic [15:0] audio;
controls_t   controls;
logic        core_reset;
logic        audio_out;

host_regs_t  model_regs;
key_state_t  model_keys;
logic        model_ext;
logic        model_brk;
int          ctrl_errors;
int          reset_errors;
int          dac_errors;
int          wait_timeouts;

arcade_shell i_arcade_shell (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.spi_sck    (spi_sck),
	.spi_ss     (spi_ss),
	.spi_di     (spi_di),
	.audio      (audio),
	.controls   (controls),
	.core_reset (core_reset),
	.audio_out  (audio_out)
);

`include "tb_tasks.svh"

initial begin
	clk_sys = 1'b0;
	forever #2 clk_sys = ~clk_sys;
end

initial begin
	logic [31:0] rnd;
	rnd           = $urandom(32'h8e23_3941);
	reset         = 1'b1;
	spi_sck       = 1'b0;
	spi_ss        = 1'b1;  // no frame open
	spi_di        = 1'b0;
	audio         = '0;
	model_regs    = '0;
	model_keys    = '0;
	model_ext     = 1'b0;
	model_brk     = 1'b0;
	ctrl_errors   = 0;
	reset_errors  = 0;
	dac_errors    = 0;
	wait_timeouts = 0;

	repeat (4) @(posedge clk_sys);
	#1;
	check_reset(core_reset, 1'b1, "core_reset in reset");
	check_reset(audio_out, 1'b0, "audio_out in reset");
	check_controls(controls, '0, "in reset");
	reset = 1'b0;
	settle_and_check("after reset");

	// ~~~~~~~~~~~~~~~~~~~~ host registers
	repeat (40) random_host_frame(1'b1);
	repeat (30) random_host_frame(1'b0);  // reset sources toggle too

	// ~~~~~~~~~~~~~~~~~~~~ keyboard
	rnd        = $urandom;
	model_regs = '0;
	model_regs.status[2] = rnd[0];  // keys are seen through a random orientation
	send_reg(`SPI_CMD_JOY0, 8'h00);
	send_reg(`SPI_CMD_JOY1, 8'h00);
	send_reg(`SPI_CMD_BUTTONS, 8'h00);
	send_status(model_regs.status);
	settle_and_check("cleared host registers");
	repeat (120) random_scan_step();

	// ~~~~~~~~~~~~~~~~~~~~ audio
	repeat (4) measure_dac();

	$display("summary: %0d control, %0d reset, %0d dac errors, %0d timeouts",
		ctrl_errors, reset_errors, dac_errors, wait_timeouts);
	if (ctrl_errors + reset_errors + dac_errors + wait_timeouts == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

// File: list.f
+incdir+common
+incdir+dv
common/shell_pkg.sv
spi_user_io/spi_user_io.sv
rtl/ps2_key_decoder.sv
rtl/control_mapper.sv
rtl/sigma_delta_dac.sv
rtl/arcade_shell.sv
dv/tb_arcade_shell.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module tb_arcade_shell --Mdir obj_dir -o tb_arcade_shell

./obj_dir/tb_arcade_shell 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
